// ==== include/bpu_params.svh ====
`ifndef BPU_PARAMS_SVH
`define BPU_PARAMS_SVH

// address width of the fetch path
`define XLEN 32

// bits of global branch history carried per block
`define BRHIST_LEN 16

// bytes covered by one sequential fetch block
`define FETCH_BLOCK_BYTES 16

// micro btb entries, direct mapped
`define UBTB_DEPTH 32

// fetch target queue entries
`define FTQ_DEPTH 8

// first fetch address out of reset
`define INIT_PC 32'h8000_0000

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the frontend testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_frontend -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output="$(./obj_dir/sim_tb)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TB PASSED"; then
    exit 0
fi
exit 1

// ==== source/bpu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bpu_params.svh"

module bpu import bpu_pkg::*; (
    input  wire               clk,
    input  wire               rst,

    // backend redirect
    input  wire               i_squash_vld,
    input  wire [`XLEN-1:0]   i_squash_pc,

    // training
    input  wire               i_commit_vld,
    input  wire bp_update_t   i_commit_info,

    // toward ftq
    input  wire               i_ftq_rdy,
    output logic              o_pred_vld,
    output bp_block_t         o_pred_block
);

    logic                   advance;
    logic                   pred_accept;

    logic [`XLEN-1:0]       s0_pc;
    logic [`XLEN-1:0]       s0_npc;
    logic                   s0_hit;
    ubtb_entry_t            s0_entry;

    logic                   s1_vld;
    logic [`XLEN-1:0]       s1_pc;
    logic                   s1_hit;
    ubtb_entry_t            s1_entry;

    logic                   s2_vld;
    logic [`XLEN-1:0]       s2_pc;
    logic                   s2_hit;
    ubtb_entry_t            s2_entry;

    logic [`BRHIST_LEN-1:0] spec_hist;
    bp_block_t              s2_block;

    // the whole pipe stalls while the ftq is full
    assign advance     = i_ftq_rdy;
    assign pred_accept = o_pred_vld && i_ftq_rdy;

    ubtb u_ubtb (
        .clk           (clk),
        .rst           (rst),
        .i_lookup_pc   (s0_pc),
        .o_hit         (s0_hit),
        .o_entry       (s0_entry),
        .i_update      (i_commit_vld),
        .i_update_info (i_commit_info)
    );

    branch_history u_branch_history (
        .clk           (clk),
        .rst           (rst),
        .i_advance     (pred_accept),
        .i_spec_taken  (s2_block.taken),
        .i_commit_vld  (i_commit_vld),
        .i_commit_info (i_commit_info),
        .i_squash_vld  (i_squash_vld),
        .o_spec_hist   (spec_hist)
    );

    // s0 next pc, ubtb hit follows its counter
    always_comb begin
        if (s0_hit) begin
            s0_npc = counter_taken(s0_entry.scnt) ? s0_entry.target_addr
                                                  : s0_entry.fallthru_addr;
        end else begin
            s0_npc = s0_pc + BLOCK_BYTES;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s0_pc  <= `INIT_PC;
            s1_vld <= 1'b0;
            s2_vld <= 1'b0;
        end else if (i_squash_vld) begin
            s0_pc  <= i_squash_pc;
            s1_vld <= 1'b0;
            s2_vld <= 1'b0;
        end else if (advance) begin
            s0_pc  <= s0_npc;
            s1_vld <= 1'b1;
            s2_vld <= s1_vld;
        end
    end

    // stage payload
    always_ff @(posedge clk) begin
        if (advance) begin
            s1_pc    <= s0_pc;
            s1_hit   <= s0_hit;
            s1_entry <= s0_entry;
            s2_pc    <= s1_pc;
            s2_hit   <= s1_hit;
            s2_entry <= s1_entry;
        end
    end

    // build the block out of the s2 lookup result
    always_comb begin
        s2_block.start_addr  = s2_pc;
        s2_block.hit_on_ubtb = s2_hit;
        s2_block.ghist       = spec_hist;
        if (s2_hit) begin
            s2_block.end_addr    = s2_entry.fallthru_addr;
            s2_block.taken       = counter_taken(s2_entry.scnt);
            s2_block.target_addr = s2_entry.target_addr;
            s2_block.ubtb_scnt   = s2_entry.scnt;
            s2_block.next_addr   = s2_block.taken ? s2_entry.target_addr
                                                  : s2_entry.fallthru_addr;
        end else begin
            s2_block.end_addr    = s2_pc + BLOCK_BYTES;
            s2_block.taken       = 1'b0;
            s2_block.target_addr = '0;
            s2_block.ubtb_scnt   = 2'd0;
            s2_block.next_addr   = s2_block.end_addr;
        end
    end

    assign o_pred_vld   = s2_vld;
    assign o_pred_block = s2_block;

endmodule

`default_nettype wire

// ==== source/bpu_pkg.sv ====
`default_nettype none

`include "bpu_params.svh"

package bpu_pkg;

    // derived field widths
    localparam int OFFSET_W   = $clog2(`FETCH_BLOCK_BYTES);
    localparam int UBTB_IDX_W = $clog2(`UBTB_DEPTH);
    localparam int UBTB_TAG_W = `XLEN - OFFSET_W - UBTB_IDX_W;

    localparam logic [`XLEN-1:0] BLOCK_BYTES = `XLEN'(`FETCH_BLOCK_BYTES);

    typedef logic [`XLEN-1:0]       addr_t;
    typedef logic [`BRHIST_LEN-1:0] ghist_t;

    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_COND = 2'd1,
        BR_JUMP = 2'd2,
        BR_RET  = 2'd3
    } branch_type_e;

    // one fetch block, range is [start_addr, end_addr)
    typedef struct packed {
        addr_t      start_addr;
        addr_t      end_addr;
        addr_t      next_addr;
        logic       taken;
        addr_t      target_addr;
        logic       hit_on_ubtb;
        logic [1:0] ubtb_scnt;
        ghist_t     ghist;
    } bp_block_t;

    // one retired block coming back from the backend
    typedef struct packed {
        addr_t        start_addr;
        addr_t        fallthru_addr;
        addr_t        target_addr;
        logic         taken;
        branch_type_e branch_type;
        logic         mispred;
        logic         hit_on_ubtb;
        logic [1:0]   ubtb_scnt;
    } bp_update_t;

    typedef struct packed {
        logic                  valid;
        logic [UBTB_TAG_W-1:0] tag;
        logic [1:0]            scnt;
        addr_t                 fallthru_addr;
        addr_t                 target_addr;
    } ubtb_entry_t;

    // 2-bit saturating counter step
    function automatic logic [1:0] counter_update(input logic [1:0] cnt, input logic taken);
        logic [1:0] res;
        res = cnt;
        if (taken && (cnt != 2'd3)) begin
            res = cnt + 2'd1;
        end else if (!taken && (cnt != 2'd0)) begin
            res = cnt - 2'd1;
        end
        return res;
    endfunction

    // weakly or strongly taken
    function automatic logic counter_taken(input logic [1:0] cnt);
        return cnt[1];
    endfunction

endpackage

`default_nettype wire

// ==== source/branch_history.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bpu_params.svh"

module branch_history import bpu_pkg::*; (
    input  wire                     clk,
    input  wire                     rst,

    // accepted prediction and its taken bit
    input  wire                     i_advance,
    input  wire                     i_spec_taken,

    input  wire                     i_commit_vld,
    input  wire bp_update_t         i_commit_info,

    input  wire                     i_squash_vld,

    output logic [`BRHIST_LEN-1:0]  o_spec_hist
);

    logic [`BRHIST_LEN-1:0] spec_hist_q;
    logic [`BRHIST_LEN-1:0] arch_hist_q;
    logic [`BRHIST_LEN-1:0] arch_hist_nxt;
    logic                   commit_is_branch;

    // only real branches leave a mark in the history
    assign commit_is_branch = i_commit_vld && (i_commit_info.branch_type != BR_NONE);

    always_comb begin
        arch_hist_nxt = arch_hist_q;
        if (commit_is_branch) begin
            arch_hist_nxt = {arch_hist_q[`BRHIST_LEN-2:0], i_commit_info.taken};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            spec_hist_q <= '0;
            arch_hist_q <= '0;
        end else begin
            arch_hist_q <= arch_hist_nxt;
            // squash restores from arch, same-cycle commit included
            if (i_squash_vld) begin
                spec_hist_q <= arch_hist_nxt;
            end else if (i_advance) begin
                spec_hist_q <= {spec_hist_q[`BRHIST_LEN-2:0], i_spec_taken};
            end
        end
    end

    assign o_spec_hist = spec_hist_q;

endmodule

`default_nettype wire

// ==== source/frontend_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bpu_params.svh"

module frontend_top import bpu_pkg::*; (
    input  wire               clk,
    input  wire               rst,

    input  wire               i_squash_vld,
    input  wire [`XLEN-1:0]   i_squash_pc,

    input  wire               i_commit_vld,
    input  wire bp_update_t   i_commit_info,

    input  wire               i_fetch_rdy,
    output logic              o_fetch_vld,
    output bp_block_t         o_fetch_block
);

    logic      pred_vld;
    bp_block_t pred_block;
    logic      ftq_rdy;

    bpu u_bpu (
        .clk           (clk),
        .rst           (rst),
        .i_squash_vld  (i_squash_vld),
        .i_squash_pc   (i_squash_pc),
        .i_commit_vld  (i_commit_vld),
        .i_commit_info (i_commit_info),
        .i_ftq_rdy     (ftq_rdy),
        .o_pred_vld    (pred_vld),
        .o_pred_block  (pred_block)
    );

    // backend squash also drops everything still queued
    ftq u_ftq (
        .clk           (clk),
        .rst           (rst),
        .i_flush       (i_squash_vld),
        .i_push_vld    (pred_vld),
        .i_push_block  (pred_block),
        .o_push_rdy    (ftq_rdy),
        .i_pop_rdy     (i_fetch_rdy),
        .o_pop_vld     (o_fetch_vld),
        .o_pop_block   (o_fetch_block)
    );

endmodule

`default_nettype wire

// ==== source/ftq.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bpu_params.svh"

module ftq import bpu_pkg::*; (
    input  wire              clk,
    input  wire              rst,
    input  wire              i_flush,

    // from bpu
    input  wire              i_push_vld,
    input  wire bp_block_t   i_push_block,
    output logic             o_push_rdy,

    // to fetch
    input  wire              i_pop_rdy,
    output logic             o_pop_vld,
    output bp_block_t        o_pop_block
);

    localparam int PTR_W = $clog2(`FTQ_DEPTH);
    localparam int CNT_W = $clog2(`FTQ_DEPTH + 1);

    bp_block_t        mem [`FTQ_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`FTQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(`FTQ_DEPTH));
    assign o_pop_vld = (count != '0);
    assign do_pop    = o_pop_vld && i_pop_rdy;
    // a full queue still takes a push when fetch pops in the same cycle
    assign o_push_rdy = !full || do_pop;
    assign do_push    = i_push_vld && o_push_rdy;

    assign o_pop_block = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push && !i_flush) begin
            mem[wr_ptr] <= i_push_block;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/ubtb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bpu_params.svh"

module ubtb import bpu_pkg::*; (
    input  wire               clk,
    input  wire               rst,

    // lookup, combinational on the s0 pc
    input  wire [`XLEN-1:0]   i_lookup_pc,
    output logic              o_hit,
    output ubtb_entry_t       o_entry,

    // training from commit
    input  wire               i_update,
    input  wire bp_update_t   i_update_info
);

    ubtb_entry_t entries_q [`UBTB_DEPTH];

    logic [UBTB_IDX_W-1:0] lookup_idx;
    logic [UBTB_TAG_W-1:0] lookup_tag;

    logic [UBTB_IDX_W-1:0] upd_idx;
    logic [UBTB_TAG_W-1:0] upd_tag;
    logic                  upd_taken;
    logic                  upd_wen;
    ubtb_entry_t           upd_entry;

    // index sits right above the block offset, tag takes the rest
    assign lookup_idx = i_lookup_pc[OFFSET_W +: UBTB_IDX_W];
    assign lookup_tag = i_lookup_pc[`XLEN-1 -: UBTB_TAG_W];

    assign o_entry = entries_q[lookup_idx];
    assign o_hit   = o_entry.valid && (o_entry.tag == lookup_tag);

    assign upd_idx = i_update_info.start_addr[OFFSET_W +: UBTB_IDX_W];
    assign upd_tag = i_update_info.start_addr[`XLEN-1 -: UBTB_TAG_W];

    // a block without a branch trains the counter as not taken
    assign upd_taken = i_update_info.taken && (i_update_info.branch_type != BR_NONE);

    // allocate on mispredict, refresh on hit
    assign upd_wen = i_update && (i_update_info.hit_on_ubtb || i_update_info.mispred);

    always_comb begin
        upd_entry.valid         = 1'b1;
        upd_entry.tag           = upd_tag;
        upd_entry.scnt          = counter_update(i_update_info.ubtb_scnt, upd_taken);
        upd_entry.fallthru_addr = i_update_info.fallthru_addr;
        upd_entry.target_addr   = i_update_info.target_addr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `UBTB_DEPTH; i++) begin
                entries_q[i].valid <= 1'b0;
            end
        end else if (upd_wen) begin
            entries_q[upd_idx] <= upd_entry;
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_frontend.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bpu_params.svh"

module tb_frontend import bpu_pkg::*; ();

    localparam int WAIT_LIMIT = 300;

    logic              clk;
    logic              rst;
    logic              i_squash_vld;
    logic [`XLEN-1:0]  i_squash_pc;
    logic              i_commit_vld;
    bp_update_t        i_commit_info;
    logic              i_fetch_rdy;
    logic              o_fetch_vld;
    bp_block_t         o_fetch_block;

    // reference model state
    logic                   m_valid [`UBTB_DEPTH];
    logic [31:0]            m_tag   [`UBTB_DEPTH];
    logic [1:0]             m_scnt  [`UBTB_DEPTH];
    logic [`XLEN-1:0]       m_ft    [`UBTB_DEPTH];
    logic [`XLEN-1:0]       m_tgt   [`UBTB_DEPTH];
    logic [`BRHIST_LEN-1:0] arch_hist;
    logic [`BRHIST_LEN-1:0] exp_hist;
    logic [`XLEN-1:0]       exp_pc;

    integer seed;
    int     stall_left;
    logic   rand_stall;

    frontend_top dut (
        .clk           (clk),
        .rst           (rst),
        .i_squash_vld  (i_squash_vld),
        .i_squash_pc   (i_squash_pc),
        .i_commit_vld  (i_commit_vld),
        .i_commit_info (i_commit_info),
        .i_fetch_rdy   (i_fetch_rdy),
        .o_fetch_vld   (o_fetch_vld),
        .o_fetch_block (o_fetch_block)
    );

    always #20 clk = ~clk;

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic [1:0] sat_step(input logic [1:0] cnt, input logic up);
        if (up) begin
            return (cnt == 2'd3) ? cnt : cnt + 2'd1;
        end
        return (cnt == 2'd0) ? cnt : cnt - 2'd1;
    endfunction

    // expected block for a start pc under the mirrored table
    function automatic bp_block_t model_block(input logic [`XLEN-1:0] pc,
                                              input logic [`BRHIST_LEN-1:0] hist);
        bp_block_t b;
        int        idx;
        idx = int'((pc >> 4) & 32'd31);
        b = '0;
        b.start_addr = pc;
        b.ghist = hist;
        if (m_valid[idx] && (m_tag[idx] == (pc >> 9))) begin
            b.hit_on_ubtb = 1'b1;
            b.ubtb_scnt   = m_scnt[idx];
            b.end_addr    = m_ft[idx];
            b.target_addr = m_tgt[idx];
            b.taken       = (m_scnt[idx] >= 2'd2);
            b.next_addr   = b.taken ? m_tgt[idx] : m_ft[idx];
        end else begin
            b.end_addr  = pc + 32'd16;
            b.next_addr = pc + 32'd16;
        end
        return b;
    endfunction

    // fetch ready is either always high or random with long stalls
    task automatic set_fetch_rdy();
        integer r;
        if (!rand_stall) begin
            i_fetch_rdy = 1'b1;
        end else if (stall_left > 0) begin
            stall_left--;
            i_fetch_rdy = 1'b0;
        end else begin
            r = $random(seed);
            if ((r & 15) == 0) begin
                stall_left = 12 + (r[10:8]);
            end
            i_fetch_rdy = r[4] | r[5];
        end
    endtask

    task automatic pop_block(output bp_block_t blk);
        int   waited;
        logic got;
        waited = 0;
        got = 1'b0;
        while (!got) begin
            @(posedge clk);
            #2;
            set_fetch_rdy();
            @(negedge clk);
            if (o_fetch_vld && i_fetch_rdy) begin
                blk = o_fetch_block;
                got = 1'b1;
            end else begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    $display("timeout while waiting for a block at fetch");
                    $display("TB FAILED");
                    $fatal(1);
                end
            end
        end
    endtask

    task automatic check_next(output bp_block_t got);
        bp_block_t exp;
        pop_block(got);
        exp = model_block(exp_pc, exp_hist);
        check_val("start_addr", got.start_addr, exp.start_addr);
        check_val("end_addr", got.end_addr, exp.end_addr);
        check_val("next_addr", got.next_addr, exp.next_addr);
        check_val("taken", got.taken, exp.taken);
        check_val("hit_on_ubtb", got.hit_on_ubtb, exp.hit_on_ubtb);
        check_val("ubtb_scnt", got.ubtb_scnt, exp.ubtb_scnt);
        check_val("ghist", got.ghist, exp.ghist);
        if (exp.hit_on_ubtb) begin
            check_val("target_addr", got.target_addr, exp.target_addr);
        end
        exp_hist = {exp_hist[`BRHIST_LEN-2:0], exp.taken};
        exp_pc = exp.next_addr;
    endtask

    task automatic squash_to(input logic [`XLEN-1:0] pc);
        @(posedge clk);
        #2;
        i_fetch_rdy = 1'b0;
        i_squash_vld = 1'b1;
        i_squash_pc = pc;
        @(posedge clk);
        #2;
        i_squash_vld = 1'b0;
        exp_pc = pc;
        exp_hist = arch_hist;
    endtask

    task automatic send_commit(input bp_update_t info);
        int idx;
        @(posedge clk);
        #2;
        i_fetch_rdy = 1'b0;
        i_commit_vld = 1'b1;
        i_commit_info = info;
        if (info.branch_type != BR_NONE) begin
            arch_hist = {arch_hist[`BRHIST_LEN-2:0], info.taken};
        end
        if (info.mispred || info.hit_on_ubtb) begin
            idx = int'((info.start_addr >> 4) & 32'd31);
            m_valid[idx] = 1'b1;
            m_tag[idx] = info.start_addr >> 9;
            m_scnt[idx] = sat_step(info.ubtb_scnt, info.taken && (info.branch_type != BR_NONE));
            m_ft[idx] = info.fallthru_addr;
            m_tgt[idx] = info.target_addr;
        end
        @(posedge clk);
        #2;
        i_commit_vld = 1'b0;
    endtask

    function automatic bp_update_t make_commit(input logic [`XLEN-1:0] pc, input logic taken,
                                               input logic mispred, input logic hit,
                                               input logic [1:0] scnt);
        bp_update_t u;
        u.start_addr    = pc;
        u.fallthru_addr = pc + 32'h30;
        u.target_addr   = 32'h8000_2000;
        u.taken         = taken;
        u.branch_type   = BR_COND;
        u.mispred       = mispred;
        u.hit_on_ubtb   = hit;
        u.ubtb_scnt     = scnt;
        return u;
    endfunction

    task automatic test_reset_stream();
        bp_block_t b;
        check_val("fetch_vld after reset", o_fetch_vld, 1'b0);
        for (int i = 0; i < 12; i++) begin
            check_next(b);
            check_val("seq taken", b.taken, 1'b0);
        end
    endtask

    task automatic test_squash();
        bp_block_t b;
        squash_to(32'h8000_4000);
        check_next(b);
        check_val("squash start_addr", b.start_addr, 32'h8000_4000);
        for (int i = 0; i < 5; i++) begin
            check_next(b);
        end
    endtask

    task automatic test_training();
        bp_block_t b;
        logic [`XLEN-1:0] p;
        p = 32'h8000_1000;
        send_commit(make_commit(p, 1'b1, 1'b1, 1'b0, 2'd0));
        squash_to(p);
        check_next(b);
        check_val("one commit scnt", b.ubtb_scnt, 2'd1);
        check_val("one commit next", b.next_addr, p + 32'h30);
        check_next(b);
        send_commit(make_commit(p, 1'b1, 1'b1, 1'b1, 2'd1));
        squash_to(p);
        check_next(b);
        check_val("trained taken", b.taken, 1'b1);
        check_val("trained next", b.next_addr, 32'h8000_2000);
        check_next(b);
        check_val("target start", b.start_addr, 32'h8000_2000);
    endtask

    task automatic test_backpressure();
        bp_block_t b;
        rand_stall = 1'b1;
        // open with a stall long enough to fill the ftq
        stall_left = 16;
        for (int i = 0; i < 60; i++) begin
            check_next(b);
        end
        rand_stall = 1'b0;
    endtask

    task automatic test_history();
        bp_block_t b;
        send_commit(make_commit(32'h8000_7000, 1'b1, 1'b0, 1'b0, 2'd0));
        send_commit(make_commit(32'h8000_7100, 1'b0, 1'b0, 1'b0, 2'd0));
        send_commit(make_commit(32'h8000_7200, 1'b1, 1'b0, 1'b0, 2'd0));
        send_commit(make_commit(32'h8000_7300, 1'b1, 1'b0, 1'b0, 2'd0));
        squash_to(32'h8000_1000);
        check_next(b);
        check_val("ghist after squash", b.ghist, arch_hist);
        for (int i = 0; i < 6; i++) begin
            check_next(b);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        i_squash_vld = 1'b0;
        i_squash_pc = '0;
        i_commit_vld = 1'b0;
        i_commit_info = '0;
        i_fetch_rdy = 1'b0;
        seed = 15;
        stall_left = 0;
        rand_stall = 1'b0;
        arch_hist = '0;
        exp_hist = '0;
        exp_pc = `INIT_PC;
        for (int i = 0; i < `UBTB_DEPTH; i++) begin
            m_valid[i] = 1'b0;
        end
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset_stream();
        test_squash();
        test_training();
        test_backpressure();
        test_history();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
source/bpu_pkg.sv
source/branch_history.sv
source/ubtb.sv
source/bpu.sv
source/ftq.sv
source/frontend_top.sv
verif/tb_frontend.sv
